//--- exu.f
hw/exu_data_pkg.sv
hw/exu_op_pkg.sv
hw/exu_issue.sv
hw/exu_alu.sv
hw/exu_mul.sv
hw/exu_div.sv
hw/exu_hilo_wb.sv
hw/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - files:
      - hw/exu_data_pkg.sv
      - hw/exu_op_pkg.sv
      - hw/exu_issue.sv
      - hw/exu_alu.sv
      - hw/exu_mul.sv
      - hw/exu_div.sv
      - hw/exu_hilo_wb.sv
      - hw/exu_top.sv
  - target: test
    files:
      - dv/exu_checker.sv
      - dv/exu_tb.sv

//--- dv/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int MUL_STAGES = 3;
    localparam int WAIT_LIMIT = 100;

    logic             clk;
    logic             reset;
    logic             req_valid;
    exu_req_t         req;
    logic             flush;
    logic             res_valid;
    exu_res_t         res;
    logic             busy;
    logic             reject;
    logic             muldiv_done;
    int               error_count;
    int               outstanding;
    int               timeouts;
    int               seed;
    logic [TAG_W-1:0] next_tag;
    logic [XLEN-1:0]  corner [8];

    exu_top #(
        .MUL_STAGES (MUL_STAGES)
    ) i_exu_top (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .flush       (flush),
        .res_valid   (res_valid),
        .res         (res),
        .busy        (busy),
        .reject      (reject),
        .muldiv_done (muldiv_done)
    );

    exu_checker #(
        .MUL_STAGES (MUL_STAGES)
    ) i_exu_checker (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .flush       (flush),
        .res_valid   (res_valid),
        .res         (res),
        .busy        (busy),
        .reject      (reject),
        .muldiv_done (muldiv_done),
        .error_count (error_count),
        .outstanding (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #5_000_000;
        $display("simulation exceeded its time limit");
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [XLEN-1:0] pick_operand();
        int r;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            return corner[r[5:3]];  // overflow and sign corners
        end
        return $random(seed);
    endfunction

    task automatic send_req(input exu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= {op, a, b, next_tag};
        next_tag  = next_tag + 1'b1;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_done(input string what);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk);
            req_valid <= 1'b0;
            seen = muldiv_done;
        end
        if (!seen) begin
            $display("timeout waiting for %s to complete", what);
            timeouts++;
        end
    endtask

    task automatic wait_not_busy();
        logic idle_seen;
        idle_seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !idle_seen; n++) begin
            @(posedge clk);
            req_valid <= 1'b0;
            idle_seen = !busy;
        end
        if (!idle_seen) begin
            $display("timeout waiting for busy to fall");
            timeouts++;
        end
    endtask

    task automatic drain();
        logic empty;
        empty = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !empty; n++) begin
            @(negedge clk);
            empty = (outstanding == 0);
        end
        if (!empty) begin
            $display("timeout waiting for outstanding results");
            timeouts++;
        end
    endtask

    // long op then read back both halves
    task automatic run_long(input exu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        send_req(op, a, b);
        wait_done(op.name());
        send_req(OP_MFHI, '0, '0);
        send_req(OP_MFLO, '0, '0);
        idle(2);
    endtask

    initial begin
        seed      = 91936;
        timeouts  = 0;
        next_tag  = '0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        corner    = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
                      32'hffff_ffff, 32'h8000_0001, 32'h0000_001f, 32'hffff_fffe};
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 200; i++) begin
            send_req(exu_op_e'($unsigned($random(seed)) % 14), pick_operand(), pick_operand());
        end
        idle(3);

        for (int i = 0; i < 24; i++) begin
            if (i < 16) begin
                run_long(i[0] ? OP_MULTU : OP_MULT, corner[i % 8], corner[(i * 3 + 1) % 8]);
            end else begin
                run_long(i[0] ? OP_MULTU : OP_MULT, pick_operand(), pick_operand());
            end
        end

        run_long(OP_DIV, -32'sd7, 32'sd2);
        run_long(OP_DIV, 32'sd7, -32'sd2);
        for (int i = 0; i < 20; i++) begin
            if (i < 16) begin
                run_long(i[0] ? OP_DIVU : OP_DIV, corner[i % 8], corner[(i * 5 + 2) % 8]);
            end else begin
                run_long(i[0] ? OP_DIVU : OP_DIV, pick_operand(), pick_operand());
            end
        end

        // ALU traffic and rejected requests during a divide
        send_req(OP_DIVU, pick_operand(), pick_operand());
        for (int i = 0; i < 6; i++) begin
            send_req(exu_op_e'($unsigned($random(seed)) % 14), pick_operand(), pick_operand());
        end
        send_req(OP_MULT, 32'h1234_5678, 32'h9abc_def0);
        send_req(OP_MFHI, '0, '0);
        send_req(OP_MTLO, 32'hdead_beef, '0);
        send_req(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        wait_done("divide under ALU traffic");
        send_req(OP_MFHI, '0, '0);
        send_req(OP_MFLO, '0, '0);
        idle(2);

        send_req(OP_MTHI, 32'h0bad_cafe, '0);
        send_req(OP_MTLO, 32'h5a5a_a5a5, '0);
        send_req(OP_MFHI, '0, '0);
        send_req(OP_MFLO, '0, '0);
        idle(2);

        // rejected writes and a cancelled divide leave hi/lo alone
        send_req(OP_DIV, 32'h8765_4321, 32'h0000_0013);
        send_req(OP_MTLO, 32'hdead_beef, '0);
        send_req(OP_MULT, 32'h0000_0003, 32'h0000_0005);
        idle(8);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_not_busy();
        idle(40);
        send_req(OP_MFHI, '0, '0);
        send_req(OP_MFLO, '0, '0);
        idle(1);

        drain();
        $display("checker errors: %0d, timeouts: %0d", error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dv/exu_checker.sv
`timescale 1ns/1ps

module exu_checker #(
    parameter int MUL_STAGES = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  exu_op_pkg::exu_req_t   req,
    input  logic                   flush,
    input  logic                   res_valid,
    input  exu_data_pkg::exu_res_t res,
    input  logic                   busy,
    input  logic                   reject,
    input  logic                   muldiv_done,
    output int                     error_count,
    output int                     outstanding
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int DIV_CYCLES = 35;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            ovf;
        exu_hilo_t       hilo;
    } ref_out_t;

    typedef struct packed {
        logic [31:0]      due;  // cycle the result must show up
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
        logic             ovf;
    } exp_res_t;

    exp_res_t  res_q[$];
    exu_hilo_t model_hilo;
    exu_hilo_t md_hilo;
    logic      md_pending;
    logic      exp_reject;
    int        md_issue;
    int        md_due;
    int        cycle;

    // expected behavior of one operation on the architectural state
    function automatic ref_out_t ref_model(input exu_op_e op, input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b, input exu_hilo_t hilo);
        ref_out_t        r;
        logic [XLEN:0]   s;
        logic [XLEN-1:0] am;
        logic [XLEN-1:0] bm;
        logic [XLEN-1:0] qm;
        logic [XLEN-1:0] rm;
        r.data = '0;
        r.ovf  = 1'b0;
        r.hilo = hilo;
        case (op)
            OP_ADD, OP_ADDU: begin
                s      = {a[XLEN-1], a} + {b[XLEN-1], b};
                r.data = s[XLEN-1:0];
                r.ovf  = (op == OP_ADD) && (s[XLEN] != s[XLEN-1]);
            end
            OP_SUB, OP_SUBU: begin
                s      = {a[XLEN-1], a} - {b[XLEN-1], b};
                r.data = s[XLEN-1:0];
                r.ovf  = (op == OP_SUB) && (s[XLEN] != s[XLEN-1]);
            end
            OP_SLT:   r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:  r.data = (a < b) ? 32'd1 : 32'd0;
            OP_AND:   r.data = a & b;
            OP_OR:    r.data = a | b;
            OP_NOR:   r.data = ~(a | b);
            OP_XOR:   r.data = a ^ b;
            OP_SLL:   r.data = b << a[4:0];
            OP_SRL:   r.data = b >> a[4:0];
            OP_SRA:   r.data = $signed(b) >>> a[4:0];
            OP_LUI:   r.data = {b[15:0], 16'h0000};
            OP_MULT:  r.hilo = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
            OP_MULTU: r.hilo = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
            OP_DIV, OP_DIVU: begin
                am = (op == OP_DIV && a[XLEN-1]) ? -a : a;
                bm = (op == OP_DIV && b[XLEN-1]) ? -b : b;
                if (bm == '0) begin
                    qm = '1;  // divide by zero
                    rm = am;
                end else begin
                    qm = am / bm;
                    rm = am % bm;
                end
                r.hilo.lo = (op == OP_DIV && (a[XLEN-1] ^ b[XLEN-1])) ? -qm : qm;
                r.hilo.hi = (op == OP_DIV && a[XLEN-1]) ? -rm : rm;
            end
            OP_MFHI:  r.data = hilo.hi;
            OP_MFLO:  r.data = hilo.lo;
            OP_MTHI:  r.hilo.hi = a;
            OP_MTLO:  r.hilo.lo = a;
            default:  r.data = '0;
        endcase
        return r;
    endfunction

    function automatic logic is_alu_op(input exu_op_e op);
        return !(op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
                            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO});
    endfunction

    initial begin
        error_count = 0;
        outstanding = 0;
    end

    always @(posedge clk) begin : compare
        ref_out_t r;
        exp_res_t e;
        logic     exp_busy;
        if (reset) begin
            res_q.delete();
            model_hilo = '0;
            md_pending = 1'b0;
            exp_reject = 1'b0;
            cycle      = 0;
            if (res_valid || busy || reject || muldiv_done) begin
                $display("outputs not idle during reset");
                error_count++;
            end
        end else begin
            cycle    = cycle + 1;
            exp_busy = md_pending && cycle > md_issue;
            if (busy !== exp_busy) begin
                $display("CHECK FAILED busy: got %h, expected %h", busy, exp_busy);
                error_count++;
            end
            if (reject !== exp_reject) begin
                $display("CHECK FAILED reject: got %h, expected %h", reject, exp_reject);
                error_count++;
            end
            exp_reject = 1'b0;

            if (res_q.size() > 0 && res_q[0].due == cycle) begin
                e = res_q.pop_front();
                if (res_valid !== 1'b1) begin
                    $display("no result for tag %h at the expected cycle", e.tag);
                    error_count++;
                end else begin
                    if (res.tag !== e.tag) begin
                        $display("CHECK FAILED res.tag: got %h, expected %h", res.tag, e.tag);
                        error_count++;
                    end
                    if (res.data !== e.data) begin
                        $display("CHECK FAILED res.data (tag %h): got %h, expected %h",
                                 e.tag, res.data, e.data);
                        error_count++;
                    end
                    if (res.ovf !== e.ovf) begin
                        $display("CHECK FAILED res.ovf (tag %h): got %h, expected %h",
                                 e.tag, res.ovf, e.ovf);
                        error_count++;
                    end
                end
            end else if (res_valid === 1'b1) begin
                $display("result with tag %h arrived when none was due", res.tag);
                error_count++;
            end

            if (md_pending && md_due == cycle) begin
                if (muldiv_done !== 1'b1) begin
                    $display("multiply or divide did not complete at the expected cycle");
                    error_count++;
                end
                model_hilo = md_hilo;  // hi/lo written in the done edge
                md_pending = 1'b0;
            end else if (muldiv_done === 1'b1) begin
                $display("muldiv_done pulsed with no operation pending");
                error_count++;
            end
            if (flush) begin
                md_pending = 1'b0;
            end

            if (req_valid) begin
                r = ref_model(req.op, req.src1, req.src2, model_hilo);
                if (exp_busy && !is_alu_op(req.op)) begin
                    exp_reject = 1'b1;
                end else if (req.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
                    md_pending = 1'b1;
                    md_issue   = cycle;
                    md_due     = cycle + (req.op inside {OP_DIV, OP_DIVU} ?
                                          DIV_CYCLES : 2 + MUL_STAGES);
                    md_hilo    = r.hilo;
                end else if (req.op inside {OP_MTHI, OP_MTLO}) begin
                    model_hilo = r.hilo;
                end else begin
                    e.due  = cycle + 2;
                    e.tag  = req.tag;
                    e.data = r.data;
                    e.ovf  = r.ovf;
                    res_q.push_back(e);
                end
            end
            outstanding = res_q.size() + int'(md_pending);
        end
    end

endmodule

//--- hw/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int MUL_STAGES = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  exu_op_pkg::exu_req_t   req,
    input  logic                   flush,
    output logic                   res_valid,
    output exu_data_pkg::exu_res_t res,
    output logic                   busy,
    output logic                   reject,
    output logic                   muldiv_done
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    logic            alu_valid;
    exu_req_t        alu_req;
    logic            md_start;
    exu_md_start_t   md_word;
    logic            hilo_valid;
    exu_req_t        hilo_req;
    logic [XLEN-1:0] alu_data;
    logic            alu_ovf;
    logic            mul_done;
    exu_hilo_t       mul_hilo;
    logic            div_done;
    exu_hilo_t       div_hilo;

    exu_issue #(
        .MUL_STAGES (MUL_STAGES)
    ) i_exu_issue (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .flush       (flush),
        .muldiv_done (muldiv_done),  // releases busy
        .alu_valid   (alu_valid),
        .alu_req     (alu_req),
        .md_start    (md_start),
        .md_word     (md_word),
        .hilo_valid  (hilo_valid),
        .hilo_req    (hilo_req),
        .busy        (busy),
        .reject      (reject)
    );

    exu_alu i_exu_alu (
        .alu_req (alu_req),
        .data    (alu_data),
        .ovf     (alu_ovf)
    );

    exu_mul #(
        .MUL_STAGES (MUL_STAGES)
    ) i_exu_mul (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .md_start (md_start),
        .md_word  (md_word),
        .mul_done (mul_done),
        .mul_hilo (mul_hilo)
    );

    exu_div i_exu_div (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .md_start (md_start),
        .md_word  (md_word),
        .div_done (div_done),
        .div_hilo (div_hilo)
    );

    exu_hilo_wb i_exu_hilo_wb (
        .clk         (clk),
        .reset       (reset),
        .alu_valid   (alu_valid),
        .alu_tag     (alu_req.tag),
        .alu_data    (alu_data),
        .alu_ovf     (alu_ovf),
        .hilo_valid  (hilo_valid),
        .hilo_req    (hilo_req),
        .mul_done    (mul_done),
        .mul_hilo    (mul_hilo),
        .div_done    (div_done),
        .div_hilo    (div_hilo),
        .res_valid   (res_valid),
        .res         (res),
        .muldiv_done (muldiv_done)
    );

endmodule

//--- hw/exu_hilo_wb.sv
`timescale 1ns/1ps

module exu_hilo_wb (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           alu_valid,
    input  logic [exu_data_pkg::TAG_W-1:0] alu_tag,
    input  logic [exu_data_pkg::XLEN-1:0]  alu_data,
    input  logic                           alu_ovf,
    input  logic                           hilo_valid,
    input  exu_op_pkg::exu_req_t           hilo_req,
    input  logic                           mul_done,
    input  exu_data_pkg::exu_hilo_t        mul_hilo,
    input  logic                           div_done,
    input  exu_data_pkg::exu_hilo_t        div_hilo,
    output logic                           res_valid,
    output exu_data_pkg::exu_res_t         res,
    output logic                           muldiv_done
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    exu_hilo_t hilo_q;
    logic      is_read;
    logic      wr_hi;
    logic      wr_lo;

    assign is_read = hilo_valid && hilo_req.op inside {OP_MFHI, OP_MFLO};
    assign wr_hi   = hilo_valid && hilo_req.op == OP_MTHI;
    assign wr_lo   = hilo_valid && hilo_req.op == OP_MTLO;

    always_ff @(posedge clk) begin
        if (reset) begin
            hilo_q <= '0;
        end else if (mul_done) begin
            hilo_q <= mul_hilo;
        end else if (div_done) begin
            hilo_q <= div_hilo;  // remainder in hi, quotient in lo
        end else if (wr_hi) begin
            hilo_q.hi <= hilo_req.src1;
        end else if (wr_lo) begin
            hilo_q.lo <= hilo_req.src1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid   <= 1'b0;
            muldiv_done <= 1'b0;
        end else begin
            res_valid   <= alu_valid || is_read;  // one source per cycle
            muldiv_done <= mul_done || div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            res.tag  <= alu_tag;
            res.data <= alu_data;
            res.ovf  <= alu_ovf;
        end else if (is_read) begin
            res.tag  <= hilo_req.tag;
            res.data <= (hilo_req.op == OP_MFHI) ? hilo_q.hi : hilo_q.lo;
            res.ovf  <= 1'b0;
        end
    end

    // only one long op may be in flight
    a_single_done: assert property (@(posedge clk) disable iff (reset)
        !(mul_done && div_done));

endmodule

//--- hw/exu_div.sv
`timescale 1ns/1ps

module exu_div (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        md_start,
    input  exu_data_pkg::exu_md_start_t md_word,
    output logic                        div_done,
    output exu_data_pkg::exu_hilo_t     div_hilo
);
    import exu_data_pkg::*;

    localparam int MSB      = XLEN - 1;
    localparam int DIV_LAST = XLEN + 1;  // fix-up step after the iterations
    localparam int CNT_W    = $clog2(DIV_LAST + 1);

    logic             take;
    logic             iterate;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  dvs_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic [XLEN:0]    rem_sh;
    logic [XLEN+1:0]  diff;

    assign take    = md_start && md_word.is_div && !flush;
    assign iterate = cnt_q != '0 && cnt_q != CNT_W'(DIV_LAST);
    assign a_mag   = (md_word.op_signed && md_word.a[MSB]) ? -md_word.a : md_word.a;
    assign b_mag   = (md_word.op_signed && md_word.b[MSB]) ? -md_word.b : md_word.b;

    // next dividend bit shifted into the partial remainder
    assign rem_sh = {rem_q, quo_q[MSB]};
    assign diff   = {1'b0, rem_sh} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cnt_q <= '0;
        end else if (take) begin
            cnt_q <= CNT_W'(1);
        end else if (cnt_q == CNT_W'(DIV_LAST)) begin
            cnt_q <= '0;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rem_q     <= '0;
            quo_q     <= a_mag;  // quotient bits replace dividend bits
            dvs_q     <= b_mag;
            neg_quo_q <= md_word.op_signed && (md_word.a[MSB] ^ md_word.b[MSB]);
            neg_rem_q <= md_word.op_signed && md_word.a[MSB];
        end else if (iterate) begin
            if (!diff[XLEN+1]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[XLEN-1:0];  // restore
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix-up during the last step
    assign div_done    = cnt_q == CNT_W'(DIV_LAST);
    assign div_hilo.hi = neg_rem_q ? -rem_q : rem_q;
    assign div_hilo.lo = neg_quo_q ? -quo_q : quo_q;

    // a new divide only arrives at an idle divider
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        take |-> cnt_q == '0);

endmodule

//--- hw/exu_mul.sv
`timescale 1ns/1ps

module exu_mul #(
    parameter int MUL_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        md_start,
    input  exu_data_pkg::exu_md_start_t md_word,
    output logic                        mul_done,
    output exu_data_pkg::exu_hilo_t     mul_hilo
);
    import exu_data_pkg::*;

    localparam int MSB  = XLEN - 1;
    localparam int LAST = MUL_STAGES - 1;

    logic                  take;
    logic [XLEN-1:0]       a_mag;
    logic [XLEN-1:0]       b_mag;
    logic                  neg_in;
    logic [MUL_STAGES-1:0] vld_q;
    logic [MUL_STAGES-1:0] neg_q;
    logic [2*XLEN-1:0]     prod_q [MUL_STAGES];
    logic [2*XLEN-1:0]     prod_out;

    assign take   = md_start && !md_word.is_div && !flush;
    assign a_mag  = (md_word.op_signed && md_word.a[MSB]) ? -md_word.a : md_word.a;
    assign b_mag  = (md_word.op_signed && md_word.b[MSB]) ? -md_word.b : md_word.b;
    assign neg_in = md_word.op_signed && (md_word.a[MSB] ^ md_word.b[MSB]);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            vld_q <= '0;  // kills any product in flight
        end else begin
            vld_q[0] <= take;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // product enters stage 0, retiming spreads it over the chain
    always_ff @(posedge clk) begin
        prod_q[0] <= a_mag * b_mag;
        neg_q[0]  <= neg_in;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
            neg_q[i]  <= neg_q[i-1];
        end
    end

    assign prod_out = neg_q[LAST] ? -prod_q[LAST] : prod_q[LAST];
    assign mul_done = vld_q[LAST];
    assign mul_hilo = prod_out;  // upper half lands in hi

    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        $onehot0(vld_q));

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  exu_op_pkg::exu_req_t          alu_req,
    output logic [exu_data_pkg::XLEN-1:0] data,
    output logic                          ovf
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int MSB   = XLEN - 1;
    localparam int SH_W  = $clog2(XLEN);
    localparam int HALF  = XLEN / 2;

    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   b_in;
    logic [XLEN-1:0]   sum;
    logic              cout;
    logic              is_sub;
    logic              lt_s;
    logic              lt_u;
    logic [SH_W-1:0]   shamt;
    logic [2*XLEN-1:0] sr_wide;

    assign a      = alu_req.src1;
    assign b      = alu_req.src2;
    assign is_sub = alu_req.op inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};

    // one adder for add, sub and both compares
    assign b_in          = is_sub ? ~b : b;
    assign {cout, sum}   = {1'b0, a} + {1'b0, b_in} + {{XLEN{1'b0}}, is_sub};

    assign lt_s = (a[MSB] & ~b[MSB]) | (~(a[MSB] ^ b[MSB]) & sum[MSB]);
    assign lt_u = ~cout;  // borrow out of a - b

    assign shamt   = a[SH_W-1:0];  // shift amount comes from src1
    assign sr_wide = {{XLEN{alu_req.op == OP_SRA && b[MSB]}}, b} >> shamt;

    always_comb begin
        case (alu_req.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: data = sum;
            OP_SLT:  data = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: data = {{(XLEN-1){1'b0}}, lt_u};
            OP_AND:  data = a & b;
            OP_OR:   data = a | b;
            OP_NOR:  data = ~(a | b);
            OP_XOR:  data = a ^ b;
            OP_SLL:  data = b << shamt;
            OP_SRL, OP_SRA: data = sr_wide[XLEN-1:0];
            OP_LUI:  data = {b[HALF-1:0], {HALF{1'b0}}};
            default: data = '0;  // mul/div and moves handled elsewhere
        endcase
    end

    // signed overflow, add and sub only
    always_comb begin
        case (alu_req.op)
            OP_ADD:  ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            OP_SUB:  ovf = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
            default: ovf = 1'b0;
        endcase
    end

endmodule

//--- hw/exu_issue.sv
`timescale 1ns/1ps

module exu_issue #(
    parameter int MUL_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  exu_op_pkg::exu_req_t        req,
    input  logic                        flush,
    input  logic                        muldiv_done,
    output logic                        alu_valid,
    output exu_op_pkg::exu_req_t        alu_req,
    output logic                        md_start,
    output exu_data_pkg::exu_md_start_t md_word,
    output logic                        hilo_valid,
    output exu_op_pkg::exu_req_t        hilo_req,
    output logic                        busy,
    output logic                        reject
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int MUL_LAT  = MUL_STAGES + 1;  // md_start to muldiv_done
    localparam int DIV_LAT  = XLEN + 2;
    localparam int BUSY_MAX = (MUL_LAT > DIV_LAT) ? MUL_LAT : DIV_LAT;
    localparam int CNT_W    = $clog2(BUSY_MAX + 1);

    exu_class_e       req_cls;
    exu_req_t         req_q;
    logic             accept_md;
    logic             md_is_div_q;
    logic [CNT_W-1:0] busy_cnt;

    function automatic exu_class_e classify(input exu_op_e op);
        case (op)
            OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: classify = CLS_MULDIV;
            OP_MTHI, OP_MTLO:                   classify = CLS_HILO_MOVE;
            OP_MFHI, OP_MFLO:                   classify = CLS_HILO_READ;
            default:                            classify = CLS_ALU;
        endcase
    endfunction

    assign req_cls   = classify(req.op);
    assign accept_md = req_valid && req_cls == CLS_MULDIV && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid   <= 1'b0;
            md_start    <= 1'b0;
            hilo_valid  <= 1'b0;
            reject      <= 1'b0;
            busy        <= 1'b0;
            busy_cnt    <= '0;
            md_is_div_q <= 1'b0;
        end else begin
            alu_valid  <= req_valid && req_cls == CLS_ALU;  // never blocked
            md_start   <= accept_md;
            hilo_valid <= req_valid && !busy && req_cls inside {CLS_HILO_MOVE, CLS_HILO_READ};
            reject     <= req_valid && busy && req_cls != CLS_ALU;
            busy       <= accept_md || (busy && !muldiv_done && !flush);
            if (accept_md) begin
                busy_cnt    <= '0;
                md_is_div_q <= req.op inside {OP_DIV, OP_DIVU};
            end else if (busy && busy_cnt != CNT_W'(BUSY_MAX)) begin
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    assign alu_req           = req_q;
    assign hilo_req          = req_q;
    assign md_word.op_signed = req_q.op inside {OP_MULT, OP_DIV};
    assign md_word.a         = req_q.src1;
    assign md_word.b         = req_q.src2;
    assign md_word.is_div    = req_q.op inside {OP_DIV, OP_DIVU};

    // completion comes back exactly at the unit latency
    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        muldiv_done |-> busy && busy_cnt == (md_is_div_q ? CNT_W'(DIV_LAT) : CNT_W'(MUL_LAT)));

endmodule

//--- hw/exu_op_pkg.sv
package exu_op_pkg;

    // one code per supported instruction
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUB   = 5'd2,
        OP_SUBU  = 5'd3,
        OP_SLT   = 5'd4,
        OP_SLTU  = 5'd5,
        OP_AND   = 5'd6,
        OP_OR    = 5'd7,
        OP_NOR   = 5'd8,
        OP_XOR   = 5'd9,
        OP_SLL   = 5'd10,
        OP_SRL   = 5'd11,
        OP_SRA   = 5'd12,
        OP_LUI   = 5'd13,
        OP_MULT  = 5'd14,
        OP_MULTU = 5'd15,
        OP_DIV   = 5'd16,
        OP_DIVU  = 5'd17,
        OP_MFHI  = 5'd18,
        OP_MFLO  = 5'd19,
        OP_MTHI  = 5'd20,
        OP_MTLO  = 5'd21
    } exu_op_e;

    typedef enum logic [1:0] {
        CLS_ALU       = 2'd0,
        CLS_MULDIV    = 2'd1,
        CLS_HILO_MOVE = 2'd2, // mthi, mtlo
        CLS_HILO_READ = 2'd3  // mfhi, mflo
    } exu_class_e;

    typedef struct packed {
        exu_op_e                        op;
        logic [exu_data_pkg::XLEN-1:0]  src1;
        logic [exu_data_pkg::XLEN-1:0]  src2;
        logic [exu_data_pkg::TAG_W-1:0] tag;  // echoed back with the result
    } exu_req_t;

endpackage

//--- hw/exu_data_pkg.sv
package exu_data_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 4;

    // result as seen at the output of the unit
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
        logic             ovf;  // add/sub signed overflow
    } exu_res_t;

    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } exu_hilo_t;

    // start word shared by multiplier and divider
    typedef struct packed {
        logic            op_signed;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            is_div;    // selects the divider
    } exu_md_start_t;

endpackage
